/* resampler_pkg.sv */
`default_nettype none

package resampler_pkg;

    // datapath widths
    localparam int sample_w = 24;
    localparam int coef_w   = 16;
    localparam int num_ch   = 2;

    // coefficients are signed Q15
    localparam int coef_frac = 15;

    // default 2x upsampling setup, overridden from resample_top
    localparam int fir_depth_d      = 8;
    localparam int fir_depth_log2_d = 3;
    localparam int num_fir_d        = 2;
    localparam int num_fir_log2_d   = 1;
    localparam int decim_d          = 1;
    localparam int mult_latency_d   = 4;
    localparam int rb_len_log2_d    = 4;

    // per-channel engine FSM
    typedef enum logic [2:0] {
        st_idle,
        st_result,
        st_calc_pending,
        st_calc,
        st_next_fir
    } engine_state_e;

endpackage

`default_nettype wire

/* ringbuf.sv */
`timescale 1ns/10ps
`default_nettype none

module ringbuf #(
    parameter int RB_LEN_LOG2 = resampler_pkg::rb_len_log2_d
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire  [resampler_pkg::sample_w-1:0]  data_i,
    input  wire                                 we_i,
    input  wire                                 pop_i,
    input  wire  [RB_LEN_LOG2-1:0]              offset_i,
    output logic [resampler_pkg::sample_w-1:0]  data_o
);
    import resampler_pkg::*;

    localparam int depth = 2 ** RB_LEN_LOG2;

    logic [sample_w-1:0]    mem_q [depth];
    logic [RB_LEN_LOG2-1:0] wr_ptr_q;
    logic [RB_LEN_LOG2-1:0] rd_ptr_q;
    logic [RB_LEN_LOG2-1:0] rd_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            for (int i = 0; i < depth; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (we_i) begin
                mem_q[wr_ptr_q] <= data_i;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // wraps naturally at the pointer width
    assign rd_addr = rd_ptr_q + offset_i;
    assign data_o  = mem_q[rd_addr];

endmodule

`default_nettype wire

/* sample_input_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_input_bank #(
    parameter int FIRDEPTH_LOG2 = resampler_pkg::fir_depth_log2_d,
    parameter int RB_LEN_LOG2   = resampler_pkg::rb_len_log2_d
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire  [resampler_pkg::sample_w-1:0]  sample_i,
    input  wire  [resampler_pkg::num_ch-1:0]    wr_i,
    input  wire  [resampler_pkg::num_ch-1:0]    rb_pop_i,
    input  wire  [FIRDEPTH_LOG2-1:0]            rb_offset_i [resampler_pkg::num_ch],
    output logic [resampler_pkg::sample_w-1:0]  rb_data_o [resampler_pkg::num_ch]
);
    import resampler_pkg::*;

    for (genvar c = 0; c < num_ch; c++) begin : g_rb
        logic [RB_LEN_LOG2-1:0] offset_ext;
        logic [sample_w-1:0]    wr_data;

        // tap offset only spans the filter, buffer is deeper
        assign offset_ext = RB_LEN_LOG2'(rb_offset_i[c]);

        // shared input bus, only the strobed channel sees the sample
        assign wr_data = wr_i[c] ? sample_i : '0;

        ringbuf #(
            .RB_LEN_LOG2(RB_LEN_LOG2)
        ) u_rb (
            .clk     (clk),
            .rst     (rst),
            .data_i  (wr_data),
            .we_i    (wr_i[c]),
            .pop_i   (rb_pop_i[c]),
            .offset_i(offset_ext),
            .data_o  (rb_data_o[c])
        );
    end

endmodule

`default_nettype wire

/* fir_coef_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module fir_coef_rom #(
    parameter int FIRDEPTH_LOG2 = resampler_pkg::fir_depth_log2_d,
    parameter int NUM_FIR_LOG2  = resampler_pkg::num_fir_log2_d
) (
    input  wire         [NUM_FIR_LOG2+FIRDEPTH_LOG2-1:0] addr_i,
    output logic signed [resampler_pkg::coef_w-1:0]      data_o
);

    // address is {phase, tap}, each phase sums to 1.0 in Q15
    always_comb begin
        case (addr_i)
            // phase 0, tapered low-pass centred on tap 3
            0:  data_o = 16'sd256;
            1:  data_o = -16'sd1024;
            2:  data_o = 16'sd3072;
            3:  data_o = 16'sd28160;
            4:  data_o = 16'sd3072;
            5:  data_o = -16'sd1024;
            6:  data_o = 16'sd256;
            7:  data_o = 16'sd0;
            // phase 1, half-sample shift between taps 3 and 4
            8:  data_o = -16'sd512;
            9:  data_o = 16'sd2048;
            10: data_o = -16'sd5120;
            11: data_o = 16'sd19968;
            12: data_o = 16'sd19968;
            13: data_o = -16'sd5120;
            14: data_o = 16'sd2048;
            15: data_o = -16'sd512;
            default: data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* pipelined_multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

module pipelined_multiplier #(
    parameter int MULT_LATENCY = resampler_pkg::mult_latency_d
) (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  signed [resampler_pkg::sample_w-1:0]  mpcand_i,
    input  wire  signed [resampler_pkg::coef_w-1:0]    mplier_i,
    output logic signed [resampler_pkg::sample_w-1:0]  mprod_o
);
    import resampler_pkg::*;

    logic signed [sample_w+coef_w-1:0] full_prod;
    logic signed [sample_w-1:0]        scaled;
    logic signed [sample_w-1:0]        stage_q [MULT_LATENCY];

    assign full_prod = mpcand_i * mplier_i;

    // drop the Q15 fraction and keep the low sample_w bits
    assign scaled = full_prod[coef_frac +: sample_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MULT_LATENCY; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= scaled;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign mprod_o = stage_q[MULT_LATENCY-1];

endmodule

`default_nettype wire

/* resampler_1ch.sv */
`timescale 1ns/10ps
`default_nettype none

module resampler_1ch #(
    parameter int FIRDEPTH      = resampler_pkg::fir_depth_d,
    parameter int FIRDEPTH_LOG2 = resampler_pkg::fir_depth_log2_d,
    parameter int NUM_FIR       = resampler_pkg::num_fir_d,
    parameter int NUM_FIR_LOG2  = resampler_pkg::num_fir_log2_d,
    parameter int DECIM         = resampler_pkg::decim_d,
    parameter int MULT_LATENCY  = resampler_pkg::mult_latency_d
) (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        shres_ready_i,
    // coefficient ROM
    output logic        [NUM_FIR_LOG2+FIRDEPTH_LOG2-1:0] bank_addr_o,
    input  wire  signed [resampler_pkg::coef_w-1:0]    bank_data_i,
    // shared multiplier
    output logic signed [resampler_pkg::sample_w-1:0]  mpcand_o,
    output logic signed [resampler_pkg::coef_w-1:0]    mplier_o,
    input  wire  signed [resampler_pkg::sample_w-1:0]  mprod_i,
    // ring buffer
    output logic                                       rb_pop_o,
    output logic        [FIRDEPTH_LOG2-1:0]            rb_offset_o,
    input  wire         [resampler_pkg::sample_w-1:0]  rb_data_i,
    // output request
    input  wire                                        pop_i,
    output logic        [resampler_pkg::sample_w-1:0]  data_o,
    output logic                                       ack_o
);
    import resampler_pkg::*;

    // load stage, multiplier stages, accumulate stage
    localparam int pipe_depth = 1 + MULT_LATENCY + 1;
    localparam int cnt_w      = $clog2(FIRDEPTH + pipe_depth);

    localparam logic [cnt_w-1:0] taps      = cnt_w'(FIRDEPTH);
    localparam logic [cnt_w-1:0] acc_first = cnt_w'(pipe_depth - 1);
    localparam logic [cnt_w-1:0] last_idx  = cnt_w'(FIRDEPTH + pipe_depth - 1);

    localparam logic [NUM_FIR_LOG2-1:0] last_phase = NUM_FIR_LOG2'(NUM_FIR - 1);
    localparam logic [NUM_FIR_LOG2-1:0] pop_step   = NUM_FIR_LOG2'(DECIM);
    localparam logic [NUM_FIR_LOG2-1:0] pop_thresh = NUM_FIR_LOG2'(NUM_FIR - DECIM);
    localparam logic [NUM_FIR_LOG2-1:0] pop_wrap   = NUM_FIR_LOG2'(DECIM - NUM_FIR);

    engine_state_e            state_q;
    logic [cnt_w-1:0]         depth_q;
    logic [NUM_FIR_LOG2-1:0]  phase_q;
    logic [NUM_FIR_LOG2-1:0]  pop_cnt_q;
    logic signed [sample_w-1:0] sample_q;
    logic signed [coef_w-1:0] coeff_q;
    logic signed [sample_w-1:0] result_q;
    logic                     pop_q;
    logic                     computing;

    assign computing = (state_q == st_calc);

    // zero outside st_calc so the merge can OR the channels together
    assign bank_addr_o = computing ? {phase_q, depth_q[FIRDEPTH_LOG2-1:0]} : '0;
    assign rb_offset_o = depth_q[FIRDEPTH_LOG2-1:0];

    // operand registers only hold data during the tap loads
    assign mpcand_o = sample_q;
    assign mplier_o = coeff_q;
    assign rb_pop_o = pop_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= st_idle;
            depth_q   <= '0;
            phase_q   <= '0;
            pop_cnt_q <= '0;
            sample_q  <= '0;
            coeff_q   <= '0;
            result_q  <= '0;
            pop_q     <= 1'b0;
        end else begin
            pop_q    <= 1'b0;
            sample_q <= '0;
            coeff_q  <= '0;
            depth_q  <= '0;

            case (state_q)
                st_idle: begin
                    if (pop_i) begin
                        state_q <= st_result;
                    end
                end
                st_result: begin
                    // previous result is on data_o this cycle
                    result_q <= '0;
                    if (shres_ready_i) begin
                        state_q <= st_calc;
                    end else begin
                        state_q <= st_calc_pending;
                    end
                end
                st_calc_pending: begin
                    if (shres_ready_i) begin
                        state_q <= st_calc;
                    end
                end
                st_calc: begin
                    // stage 1, fetch one tap
                    if (depth_q < taps) begin
                        sample_q <= rb_data_i;
                        coeff_q  <= bank_data_i;
                    end
                    // last stage, product of tap (depth_q - acc_first) arrives
                    if (depth_q >= acc_first && depth_q < last_idx) begin
                        result_q <= result_q + mprod_i;
                    end
                    if (depth_q == last_idx) begin
                        state_q <= st_next_fir;
                    end else begin
                        depth_q <= depth_q + 1'b1;
                    end
                end
                st_next_fir: begin
                    if (phase_q == last_phase) begin
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end

                    // advance the input once a full sample has been consumed
                    if (pop_cnt_q >= pop_thresh) begin
                        pop_cnt_q <= pop_cnt_q + pop_wrap;
                        pop_q     <= 1'b1;
                    end else begin
                        pop_cnt_q <= pop_cnt_q + pop_step;
                    end

                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    assign ack_o  = (state_q == st_result);
    assign data_o = ack_o ? result_q : '0;

endmodule

`default_nettype wire

/* shared_resource_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module shared_resource_merge #(
    parameter int FIRDEPTH_LOG2 = resampler_pkg::fir_depth_log2_d,
    parameter int NUM_FIR_LOG2  = resampler_pkg::num_fir_log2_d
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire  [resampler_pkg::num_ch-1:0]     pop_i,
    input  wire                                  mult_ready_i,
    input  wire  [NUM_FIR_LOG2+FIRDEPTH_LOG2-1:0] bank_addr_i [resampler_pkg::num_ch],
    input  wire  [resampler_pkg::sample_w-1:0]   mpcand_i [resampler_pkg::num_ch],
    input  wire  [resampler_pkg::coef_w-1:0]     mplier_i [resampler_pkg::num_ch],
    input  wire  [resampler_pkg::sample_w-1:0]   data_i [resampler_pkg::num_ch],
    input  wire  [resampler_pkg::num_ch-1:0]     ack_i,
    output logic [resampler_pkg::num_ch-1:0]     shres_ready_o,
    output logic [NUM_FIR_LOG2+FIRDEPTH_LOG2-1:0] bank_addr_o,
    output logic [resampler_pkg::sample_w-1:0]   mpcand_o,
    output logic [resampler_pkg::coef_w-1:0]     mplier_o,
    output logic [resampler_pkg::sample_w-1:0]   data_o,
    output logic [resampler_pkg::num_ch-1:0]     ack_o
);
    import resampler_pkg::*;

    logic owner_q;

    // last popped channel owns ROM and multiplier, channel 0 wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= 1'b0;
        end else if (pop_i[0]) begin
            owner_q <= 1'b0;
        end else if (pop_i[1]) begin
            owner_q <= 1'b1;
        end
    end

    // idle engines drive zeros, so a plain OR selects the active one
    always_comb begin
        bank_addr_o   = '0;
        mpcand_o      = '0;
        mplier_o      = '0;
        data_o        = '0;
        shres_ready_o = '0;
        for (int c = 0; c < num_ch; c++) begin
            bank_addr_o      = bank_addr_o | bank_addr_i[c];
            mpcand_o         = mpcand_o | mpcand_i[c];
            mplier_o         = mplier_o | mplier_i[c];
            data_o           = data_o | data_i[c];
            shres_ready_o[c] = mult_ready_i && (owner_q == 1'(c));
        end
    end

    assign ack_o = ack_i;

endmodule

`default_nettype wire

/* resample_top.sv */
`timescale 1ns/10ps
`default_nettype none

module resample_top #(
    parameter int FIRDEPTH      = resampler_pkg::fir_depth_d,
    parameter int FIRDEPTH_LOG2 = resampler_pkg::fir_depth_log2_d,
    parameter int NUM_FIR       = resampler_pkg::num_fir_d,
    parameter int NUM_FIR_LOG2  = resampler_pkg::num_fir_log2_d,
    parameter int DECIM         = resampler_pkg::decim_d,
    parameter int MULT_LATENCY  = resampler_pkg::mult_latency_d,
    parameter int RB_LEN_LOG2   = resampler_pkg::rb_len_log2_d
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire  [resampler_pkg::sample_w-1:0]  sample_i,
    input  wire  [resampler_pkg::num_ch-1:0]    wr_i,
    input  wire  [resampler_pkg::num_ch-1:0]    pop_i,
    output logic [resampler_pkg::sample_w-1:0]  data_o,
    output logic [resampler_pkg::num_ch-1:0]    ack_o
);
    import resampler_pkg::*;

    localparam int addr_w = NUM_FIR_LOG2 + FIRDEPTH_LOG2;

    // input bank side
    logic [num_ch-1:0]        rb_pop;
    logic [FIRDEPTH_LOG2-1:0] rb_offset [num_ch];
    logic [sample_w-1:0]      rb_data [num_ch];

    // per-engine signals into the merge
    logic [addr_w-1:0]        eng_addr [num_ch];
    logic [sample_w-1:0]      eng_mpcand [num_ch];
    logic [coef_w-1:0]        eng_mplier [num_ch];
    logic [sample_w-1:0]      eng_data [num_ch];
    logic [num_ch-1:0]        eng_ack;
    logic [num_ch-1:0]        shres_ready;

    // shared resources
    logic [addr_w-1:0]        rom_addr;
    logic [coef_w-1:0]        rom_data;
    logic [sample_w-1:0]      mpcand;
    logic [coef_w-1:0]        mplier;
    logic [sample_w-1:0]      mprod;
    logic                     mult_ready;

    // multiplier accepts operands every cycle
    assign mult_ready = 1'b1;

    sample_input_bank #(
        .FIRDEPTH_LOG2(FIRDEPTH_LOG2),
        .RB_LEN_LOG2  (RB_LEN_LOG2)
    ) u_bank (
        .clk        (clk),
        .rst        (rst),
        .sample_i   (sample_i),
        .wr_i       (wr_i),
        .rb_pop_i   (rb_pop),
        .rb_offset_i(rb_offset),
        .rb_data_o  (rb_data)
    );

    for (genvar c = 0; c < num_ch; c++) begin : g_eng
        resampler_1ch #(
            .FIRDEPTH     (FIRDEPTH),
            .FIRDEPTH_LOG2(FIRDEPTH_LOG2),
            .NUM_FIR      (NUM_FIR),
            .NUM_FIR_LOG2 (NUM_FIR_LOG2),
            .DECIM        (DECIM),
            .MULT_LATENCY (MULT_LATENCY)
        ) u_eng (
            .clk          (clk),
            .rst          (rst),
            .shres_ready_i(shres_ready[c]),
            .bank_addr_o  (eng_addr[c]),
            .bank_data_i  (rom_data),
            .mpcand_o     (eng_mpcand[c]),
            .mplier_o     (eng_mplier[c]),
            .mprod_i      (mprod),
            .rb_pop_o     (rb_pop[c]),
            .rb_offset_o  (rb_offset[c]),
            .rb_data_i    (rb_data[c]),
            .pop_i        (pop_i[c]),
            .data_o       (eng_data[c]),
            .ack_o        (eng_ack[c])
        );
    end

    shared_resource_merge #(
        .FIRDEPTH_LOG2(FIRDEPTH_LOG2),
        .NUM_FIR_LOG2 (NUM_FIR_LOG2)
    ) u_merge (
        .clk          (clk),
        .rst          (rst),
        .pop_i        (pop_i),
        .mult_ready_i (mult_ready),
        .bank_addr_i  (eng_addr),
        .mpcand_i     (eng_mpcand),
        .mplier_i     (eng_mplier),
        .data_i       (eng_data),
        .ack_i        (eng_ack),
        .shres_ready_o(shres_ready),
        .bank_addr_o  (rom_addr),
        .mpcand_o     (mpcand),
        .mplier_o     (mplier),
        .data_o       (data_o),
        .ack_o        (ack_o)
    );

    fir_coef_rom #(
        .FIRDEPTH_LOG2(FIRDEPTH_LOG2),
        .NUM_FIR_LOG2 (NUM_FIR_LOG2)
    ) u_rom (
        .addr_i(rom_addr),
        .data_o(rom_data)
    );

    pipelined_multiplier #(
        .MULT_LATENCY(MULT_LATENCY)
    ) u_mult (
        .clk     (clk),
        .rst     (rst),
        .mpcand_i(mpcand),
        .mplier_i(mplier),
        .mprod_o (mprod)
    );

endmodule

`default_nettype wire

/* resample_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module resample_sva (
    input wire                               clk,
    input wire                               rst,
    input wire [resampler_pkg::num_ch-1:0]   pop_i,
    input wire [resampler_pkg::num_ch-1:0]   ack_o,
    input wire [resampler_pkg::sample_w-1:0] data_o,
    input resampler_pkg::engine_state_e      eng0_state_i,
    input resampler_pkg::engine_state_e      eng1_state_i
);
    import resampler_pkg::*;

    logic [num_ch-1:0] eng_idle;

    assign eng_idle[0] = (eng0_state_i == st_idle);
    assign eng_idle[1] = (eng1_state_i == st_idle);

    // consumer never pops both channels together
    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack_o))
        else $error("ack_o has more than one channel set: %b", ack_o);

    a_data_quiet: assert property (@(posedge clk) disable iff (rst)
        (ack_o == '0) |-> (data_o == '0))
        else $error("data_o is %h without an ack", data_o);

    for (genvar c = 0; c < num_ch; c++) begin : g_ch
        a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
            ack_o[c] |=> !ack_o[c])
            else $error("ack_o[%0d] high for two cycles", c);

        a_pop_ack: assert property (@(posedge clk) disable iff (rst)
            (pop_i[c] && eng_idle[c]) |=> ack_o[c])
            else $error("pop on idle channel %0d not acked in the next cycle", c);
    end

endmodule

bind resample_top resample_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .pop_i       (pop_i),
    .ack_o       (ack_o),
    .data_o      (data_o),
    .eng0_state_i(g_eng[0].u_eng.state_q),
    .eng1_state_i(g_eng[1].u_eng.state_q)
);

`default_nettype wire

/* tb_resample.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_resample;
    import resampler_pkg::*;

    localparam int clk_period = 40;
    localparam int max_rec    = 64;
    localparam int rec_words  = 5;
    // an engine is busy for 16 cycles after its ack
    localparam int pop_gap    = 19;
    localparam int max_filler = 3;
    localparam int max_rec_cycles = 1 + pop_gap + max_filler;

    logic                clk;
    logic                rst;
    logic [sample_w-1:0] sample_i;
    logic [num_ch-1:0]   wr_i;
    logic [num_ch-1:0]   pop_i;
    logic [sample_w-1:0] data_o;
    logic [num_ch-1:0]   ack_o;

    // five words per record in the order wr sample pop ack data
    logic [31:0] trace_mem [rec_words*max_rec];
    logic        trace_loaded = 1'b0;
    int          n_rec;
    int          ack_errs;
    int          data_errs;
    int          load_errs;

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    resample_top DUT (
        .clk     (clk),
        .rst     (rst),
        .sample_i(sample_i),
        .wr_i    (wr_i),
        .pop_i   (pop_i),
        .data_o  (data_o),
        .ack_o   (ack_o)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_outputs(input int rec, input logic [num_ch-1:0] exp_ack,
                                 input logic [sample_w-1:0] exp_data);
        if (ack_o !== exp_ack) begin
            ack_errs++;
            $display("** Error ack_o at record %0d: got %h, expected %h", rec, ack_o, exp_ack);
        end
        if (data_o !== exp_data) begin
            data_errs++;
            $display("** Error data_o at record %0d: got %h, expected %h", rec, data_o, exp_data);
        end
    endtask

    // one driven cycle per record followed by idle filler with zero outputs
    task automatic run_record(input int rec);
        int                  base;
        int                  gap;
        logic [num_ch-1:0]   pop;
        logic [num_ch-1:0]   exp_ack;
        logic [sample_w-1:0] exp_data;
        base     = rec_words * rec;
        pop      = trace_mem[base+2][num_ch-1:0];
        exp_ack  = trace_mem[base+3][num_ch-1:0];
        exp_data = trace_mem[base+4][sample_w-1:0];
        wr_i     = trace_mem[base][num_ch-1:0];
        sample_i = trace_mem[base+1][sample_w-1:0];
        pop_i    = pop;
        next_cycle();
        check_outputs(rec, exp_ack, exp_data);
        wr_i     = '0;
        sample_i = '0;
        pop_i    = '0;
        gap = $urandom_range(max_filler, 0);
        // let the engine finish before the next request
        if (pop != '0) begin
            gap = gap + pop_gap;
        end
        repeat (gap) begin
            next_cycle();
            check_outputs(rec, '0, '0);
        end
    endtask

    initial begin
        rst       = 1'b1;
        wr_i      = '0;
        sample_i  = '0;
        pop_i     = '0;
        n_rec     = 0;
        ack_errs  = 0;
        data_errs = 0;
        load_errs = 0;
        void'($urandom(32'h7c2b_314c));
        for (int i = 0; i < rec_words*max_rec; i++) begin
            trace_mem[i] = '1;
        end
        $readmemh("resample_trace.txt", trace_mem);
        // all ones never occurs as a write strobe field
        while (n_rec < max_rec && trace_mem[rec_words*n_rec] !== '1) begin
            n_rec++;
        end
        if (n_rec == 0) begin
            load_errs++;
            $display("The trace file resample_trace.txt is missing or holds no records");
        end
        trace_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_rec; i++) begin
            run_record(i);
        end
        $display("errors: %0d (ack_o %0d, data_o %0d, trace %0d), records run: %0d",
                 ack_errs + data_errs + load_errs, ack_errs, data_errs, load_errs, n_rec);
        if (ack_errs + data_errs + load_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (trace_loaded);
        limit_ns = (n_rec * max_rec_cycles + 50) * clk_period;
        #(limit_ns);
        $display("Timeout: the trace did not complete within %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* resample_trace.txt */
// columns: wr_i sample_i pop_i ack_o data_o, all hex, one record per line
// ack_o and data_o are the expected values in the cycle after the record
// channel 0, impulse of 1.0 at slot 3
1 000000 0 0 000000
1 000000 0 0 000000
1 000000 0 0 000000
1 008000 0 0 000000
// channel 1, constant -4096 in slots 0 to 7
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
2 fff000 0 0 000000
// alternating pops, the first ack on each channel carries zero
0 000000 1 1 000000
0 000000 2 2 000000
0 000000 1 1 006e00
0 000000 2 2 fff000
0 000000 1 1 004e00
0 000000 2 2 fff000
// two more channel 0 samples in slots 4 and 5
1 010000 0 0 000000
1 ffffff 0 0 000000
0 000000 1 1 000c00
0 000000 2 2 fff000
0 000000 1 1 0087ff
0 000000 2 2 ffefc0
0 000000 1 1 0013ff
0 000000 2 2 fff020

/* project.f */
resampler_pkg.sv
ringbuf.sv
sample_input_bank.sv
fir_coef_rom.sv
pipelined_multiplier.sv
resampler_1ch.sv
shared_resource_merge.sv
resample_top.sv
resample_sva.sv
tb_resample.sv

/* run.sh */
#!/bin/sh
# compile and run the resampler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    -f project.f --top-module tb_resample -o Vtb_resample
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_resample)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1
